//--- hw/mhp_pkg.sv
`default_nettype none

package mhp_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  buf_addr_t;
  typedef logic [15:0] node_addr_t;
  typedef logic [15:0] sum_t;
  typedef logic [4:0]  cmd_t;

  // src 0..1, dst 2..3, size 4..5, type 6
  localparam buf_addr_t HEADER_BYTES    = 8'd7;
  localparam int        IDLE_GAP_CYCLES = 63;
  localparam buf_addr_t TX_FRAME_BYTES  = 8'd16;
  localparam int        ACK_TYPE_BIT    = 4;

  localparam cmd_t CMD_PING       = 5'd1;
  localparam cmd_t CMD_ADDR_REQ   = 5'd3;
  localparam cmd_t CMD_ADDR_GRANT = 5'd4;

  localparam buf_addr_t LEN_PING       = 8'd10;
  localparam buf_addr_t LEN_ADDR_REQ   = 8'd11;
  localparam buf_addr_t LEN_ADDR_GRANT = 8'd11;

  typedef enum logic [3:0] {
    CP_IDLE,
    CP_HDR_ADDR,
    CP_HDR_WAIT,
    CP_HDR_LOAD,
    CP_SELECT,
    CP_TEMPLATE,
    CP_PATCH,
    CP_CHECKSUM,
    CP_DONE
  } cp_state_t;

  typedef enum logic [2:0] {
    LINK_IDLE,
    LINK_READ,
    LINK_READ_GAP,
    LINK_PREPARE,
    LINK_TX_ADDR,
    LINK_TX_WAIT,
    LINK_TX_DATA
  } link_state_t;

endpackage

`default_nettype wire

//--- hw/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer
  import mhp_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_a_we,
  input  buf_addr_t i_a_addr,
  input  byte_t     i_a_wdata,
  input  logic      i_b_we,
  input  buf_addr_t i_b_addr,
  input  byte_t     i_b_wdata,
  output byte_t     o_rdata
);

  byte_t     mem [256];
  logic      we;
  buf_addr_t addr;
  byte_t     wdata;

  // idle requesters hold all zeros
  assign we    = i_a_we | i_b_we;
  assign addr  = i_a_addr | i_b_addr;
  assign wdata = i_a_wdata | i_b_wdata;

  // registered read, old data on a write cycle
  always_ff @(posedge i_clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    o_rdata <= mem[addr];
  end

  // link side and processing side never write together
  a_single_writer: assert property (@(posedge i_clk) !(i_a_we && i_b_we))
    else $error("frame buffer written by both requesters");

endmodule

`default_nettype wire

//--- hw/reply_template.sv
`timescale 1ns/1ps
`default_nettype none

module reply_template
  import mhp_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_start,
  input  cmd_t      i_cmd,
  output logic      o_done,
  output logic      o_known,
  output buf_addr_t o_len,
  output logic      o_mem_we,
  output buf_addr_t o_mem_addr,
  output byte_t     o_mem_wdata
);

  logic      busy;
  cmd_t      cmd_q;
  buf_addr_t idx;

  // zero length marks an unknown command
  function automatic buf_addr_t tpl_len(input cmd_t cmd);
    case (cmd)
      CMD_PING:       return LEN_PING;
      CMD_ADDR_REQ:   return LEN_ADDR_REQ;
      CMD_ADDR_GRANT: return LEN_ADDR_GRANT;
      default:        return 8'd0;
    endcase
  endfunction

  function automatic byte_t tpl_byte(input cmd_t cmd, input buf_addr_t pos);
    byte_t b;
    b = 8'h00;
    case (pos)
      8'd0, 8'd1: b = 8'hff;
      8'd5: b = (cmd == CMD_ADDR_GRANT) ? 8'h02 : 8'h01;
      8'd6: begin
        case (cmd)
          CMD_PING:     b = 8'h81;
          CMD_ADDR_REQ: b = 8'h83;
          default:      b = 8'h92;
        endcase
      end
      // grant payload
      8'd7: b = (cmd == CMD_ADDR_GRANT) ? 8'h01 : 8'h00;
      8'd8: b = (cmd == CMD_ADDR_GRANT) ? 8'h20 : 8'h00;
      default: b = 8'h00;
    endcase
    return b;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy        <= 1'b0;
      cmd_q       <= '0;
      idx         <= '0;
      o_done      <= 1'b0;
      o_known     <= 1'b0;
      o_len       <= '0;
      o_mem_we    <= 1'b0;
      o_mem_addr  <= '0;
      o_mem_wdata <= '0;
    end else begin
      o_done      <= 1'b0;
      o_mem_we    <= 1'b0;
      o_mem_addr  <= '0;
      o_mem_wdata <= '0;
      if (busy) begin
        if (idx == o_len) begin
          busy   <= 1'b0;
          o_done <= 1'b1;
        end else begin
          o_mem_we    <= 1'b1;
          o_mem_addr  <= idx;
          o_mem_wdata <= tpl_byte(cmd_q, idx);
          idx         <= idx + 1'b1;
        end
      end else if (i_start) begin
        cmd_q   <= i_cmd;
        idx     <= '0;
        o_len   <= tpl_len(i_cmd);
        o_known <= (tpl_len(i_cmd) != 8'd0);
        if (tpl_len(i_cmd) == 8'd0) begin
          o_done <= 1'b1;
        end else begin
          busy <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/checksum_unit.sv
`timescale 1ns/1ps
`default_nettype none

module checksum_unit
  import mhp_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_start,
  input  buf_addr_t i_len,
  output logic      o_done,
  output logic      o_mem_we,
  output buf_addr_t o_mem_addr,
  output byte_t     o_mem_wdata,
  input  byte_t     i_mem_rdata
);

  typedef enum logic [2:0] {
    CS_IDLE,
    CS_READ,
    CS_DRAIN,
    CS_WR_LO,
    CS_FINISH
  } cs_state_t;

  cs_state_t state;
  buf_addr_t rd_idx;
  buf_addr_t last_idx;
  buf_addr_t len_q;
  sum_t      sum;
  // address on the bus, then data back from the buffer
  logic      addr_vld;
  logic      data_vld;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= CS_IDLE;
      rd_idx      <= '0;
      last_idx    <= '0;
      len_q       <= '0;
      addr_vld    <= 1'b0;
      data_vld    <= 1'b0;
      o_done      <= 1'b0;
      o_mem_we    <= 1'b0;
      o_mem_addr  <= '0;
      o_mem_wdata <= '0;
    end else begin
      o_done      <= 1'b0;
      o_mem_we    <= 1'b0;
      o_mem_addr  <= '0;
      o_mem_wdata <= '0;
      addr_vld    <= 1'b0;
      data_vld    <= addr_vld;
      if (data_vld) begin
        sum <= sum + sum_t'(i_mem_rdata);
      end
      case (state)
        CS_IDLE: begin
          if (i_start) begin
            sum      <= '0;
            rd_idx   <= '0;
            len_q    <= i_len;
            last_idx <= i_len - 8'd3;
            state    <= CS_READ;
          end
        end
        // one read per cycle over the payload
        CS_READ: begin
          o_mem_addr <= rd_idx;
          addr_vld   <= 1'b1;
          rd_idx     <= rd_idx + 1'b1;
          if (rd_idx == last_idx) begin
            state <= CS_DRAIN;
          end
        end
        CS_DRAIN: begin
          if (!addr_vld && !data_vld) begin
            o_mem_we    <= 1'b1;
            o_mem_addr  <= len_q - 8'd2;
            o_mem_wdata <= sum[15:8];
            state       <= CS_WR_LO;
          end
        end
        CS_WR_LO: begin
          o_mem_we    <= 1'b1;
          o_mem_addr  <= len_q - 8'd1;
          o_mem_wdata <= sum[7:0];
          state       <= CS_FINISH;
        end
        CS_FINISH: begin
          o_done <= 1'b1;
          state  <= CS_IDLE;
        end
        default: state <= CS_IDLE;
      endcase
    end
  end

  // room for at least the two checksum bytes and one summed byte
  a_len_min: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_start && state == CS_IDLE) |-> i_len >= 8'd3)
    else $error("checksum started with reply length below 3");

endmodule

`default_nettype wire

//--- hw/command_processor.sv
`timescale 1ns/1ps
`default_nettype none

module command_processor
  import mhp_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_start,
  output logic      o_done,
  output logic      o_reply_valid,
  output buf_addr_t o_reply_len,
  output logic      o_grant_seen,
  input  logic      i_granted,
  output logic      o_mem_we,
  output buf_addr_t o_mem_addr,
  output byte_t     o_mem_wdata,
  input  byte_t     i_mem_rdata
);

  cp_state_t  state;
  logic [2:0] hdr_idx;
  logic [2:0] patch_idx;
  node_addr_t src_addr;
  node_addr_t dst_addr;
  byte_t      frame_type;
  cmd_t       cmd;
  byte_t      patch_byte;

  logic       own_we;
  buf_addr_t  own_addr;
  byte_t      own_wdata;

  logic       tpl_start;
  logic       tpl_done;
  logic       tpl_known;
  buf_addr_t  tpl_len;
  logic       tpl_we;
  buf_addr_t  tpl_addr;
  byte_t      tpl_wdata;

  logic       cs_start;
  logic       cs_done;
  logic       cs_we;
  buf_addr_t  cs_addr;
  byte_t      cs_wdata;

  reply_template u_reply_template (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (tpl_start),
    .i_cmd       (cmd),
    .o_done      (tpl_done),
    .o_known     (tpl_known),
    .o_len       (tpl_len),
    .o_mem_we    (tpl_we),
    .o_mem_addr  (tpl_addr),
    .o_mem_wdata (tpl_wdata)
  );

  checksum_unit u_checksum_unit (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (cs_start),
    .i_len       (o_reply_len),
    .o_done      (cs_done),
    .o_mem_we    (cs_we),
    .o_mem_addr  (cs_addr),
    .o_mem_wdata (cs_wdata),
    .i_mem_rdata (i_mem_rdata)
  );

  assign o_mem_we    = own_we | tpl_we | cs_we;
  assign o_mem_addr  = own_addr | tpl_addr | cs_addr;
  assign o_mem_wdata = own_wdata | tpl_wdata | cs_wdata;

  // reply goes back to the sender
  always_comb begin
    case (patch_idx)
      3'd0:    patch_byte = dst_addr[15:8];
      3'd1:    patch_byte = dst_addr[7:0];
      3'd2:    patch_byte = src_addr[15:8];
      default: patch_byte = src_addr[7:0];
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state         <= CP_IDLE;
      hdr_idx       <= '0;
      patch_idx     <= '0;
      cmd           <= '0;
      own_we        <= 1'b0;
      own_addr      <= '0;
      own_wdata     <= '0;
      tpl_start     <= 1'b0;
      cs_start      <= 1'b0;
      o_done        <= 1'b0;
      o_reply_valid <= 1'b0;
      o_reply_len   <= '0;
      o_grant_seen  <= 1'b0;
    end else begin
      tpl_start <= 1'b0;
      cs_start  <= 1'b0;
      o_done    <= 1'b0;
      own_we    <= 1'b0;
      case (state)
        CP_IDLE: begin
          hdr_idx <= '0;
          if (i_start) begin
            state <= CP_HDR_ADDR;
          end
        end
        //////////////////////////////
        // header read
        CP_HDR_ADDR: begin
          own_addr <= buf_addr_t'(hdr_idx);
          state    <= CP_HDR_WAIT;
        end
        CP_HDR_WAIT: begin
          own_addr <= '0;
          state    <= CP_HDR_LOAD;
        end
        CP_HDR_LOAD: begin
          case (hdr_idx)
            3'd0:    src_addr[15:8] <= i_mem_rdata;
            3'd1:    src_addr[7:0]  <= i_mem_rdata;
            3'd2:    dst_addr[15:8] <= i_mem_rdata;
            3'd3:    dst_addr[7:0]  <= i_mem_rdata;
            3'd6:    frame_type     <= i_mem_rdata;
            default: ;
          endcase
          hdr_idx <= hdr_idx + 1'b1;
          state   <= (hdr_idx == 3'(HEADER_BYTES - 1)) ? CP_SELECT : CP_HDR_ADDR;
        end
        //////////////////////////////
        // command and reply build
        CP_SELECT: begin
          o_reply_valid <= 1'b0;
          o_grant_seen  <= 1'b0;
          if (frame_type[ACK_TYPE_BIT]) begin
            o_done <= 1'b1;
            state  <= CP_DONE;
          end else begin
            // no address yet, so every request gets a grant
            cmd       <= i_granted ? frame_type[4:0] : CMD_ADDR_GRANT;
            tpl_start <= 1'b1;
            state     <= CP_TEMPLATE;
          end
        end
        CP_TEMPLATE: begin
          if (tpl_done) begin
            if (tpl_known) begin
              o_reply_len <= tpl_len;
              patch_idx   <= '0;
              state       <= CP_PATCH;
            end else begin
              o_done <= 1'b1;
              state  <= CP_DONE;
            end
          end
        end
        CP_PATCH: begin
          if (patch_idx == 3'd4) begin
            own_addr  <= '0;
            own_wdata <= '0;
            cs_start  <= 1'b1;
            state     <= CP_CHECKSUM;
          end else begin
            own_we    <= 1'b1;
            own_addr  <= buf_addr_t'(patch_idx);
            own_wdata <= patch_byte;
            patch_idx <= patch_idx + 1'b1;
          end
        end
        CP_CHECKSUM: begin
          if (cs_done) begin
            o_reply_valid <= 1'b1;
            o_grant_seen  <= (cmd == CMD_ADDR_GRANT);
            o_done        <= 1'b1;
            state         <= CP_DONE;
          end
        end
        CP_DONE: state <= CP_IDLE;
        default: state <= CP_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/link_controller.sv
`timescale 1ns/1ps
`default_nettype none

module link_controller
  import mhp_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_rready,
  input  byte_t     i_rdata,
  output logic      o_rreq,
  input  logic      i_wready,
  output byte_t     o_wdata,
  output logic      o_wvalid,
  output logic      o_addr_granted,
  output logic      o_proc_start,
  input  logic      i_proc_done,
  input  logic      i_reply_valid,
  input  buf_addr_t i_reply_len,
  input  logic      i_grant_seen,
  output logic      o_mem_we,
  output buf_addr_t o_mem_addr,
  output byte_t     o_mem_wdata,
  input  byte_t     i_mem_rdata
);

  link_state_t state;
  buf_addr_t   rx_cnt;
  buf_addr_t   tx_cnt;
  buf_addr_t   reply_len;
  logic [5:0]  gap_cnt;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state          <= LINK_IDLE;
      rx_cnt         <= '0;
      tx_cnt         <= '0;
      reply_len      <= '0;
      gap_cnt        <= '0;
      o_rreq         <= 1'b0;
      o_wvalid       <= 1'b0;
      o_addr_granted <= 1'b0;
      o_proc_start   <= 1'b0;
      o_mem_we       <= 1'b0;
      o_mem_addr     <= '0;
      o_mem_wdata    <= '0;
    end else begin
      o_rreq   <= 1'b0;
      o_wvalid <= 1'b0;
      o_mem_we <= 1'b0;
      case (state)
        //////////////////////////////
        // receive
        LINK_IDLE: begin
          rx_cnt      <= '0;
          o_mem_addr  <= '0;
          o_mem_wdata <= '0;
          if (i_rready) begin
            o_rreq <= 1'b1;
            state  <= LINK_READ;
          end
        end
        LINK_READ: begin
          o_mem_we    <= 1'b1;
          o_mem_addr  <= rx_cnt;
          o_mem_wdata <= i_rdata;
          rx_cnt      <= rx_cnt + 1'b1;
          gap_cnt     <= '0;
          state       <= LINK_READ_GAP;
        end
        LINK_READ_GAP: begin
          o_mem_addr  <= '0;
          o_mem_wdata <= '0;
          if (i_rready) begin
            o_rreq <= 1'b1;
            state  <= LINK_READ;
          end else if (gap_cnt == 6'(IDLE_GAP_CYCLES - 1)) begin
            // too short for a header, drop it
            if (rx_cnt < HEADER_BYTES) begin
              state <= LINK_IDLE;
            end else begin
              o_proc_start <= 1'b1;
              state        <= LINK_PREPARE;
            end
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        LINK_PREPARE: begin
          if (i_proc_done) begin
            o_proc_start <= 1'b0;
            if (i_grant_seen) begin
              o_addr_granted <= 1'b1;
            end
            reply_len <= i_reply_len;
            tx_cnt    <= '0;
            state     <= i_reply_valid ? LINK_TX_ADDR : LINK_IDLE;
          end
        end
        //////////////////////////////
        // transmit, padded to a fixed length
        LINK_TX_ADDR: begin
          o_mem_addr <= tx_cnt;
          state      <= LINK_TX_WAIT;
        end
        LINK_TX_WAIT: begin
          // sink readiness only gates the first byte
          if (tx_cnt != 8'd0 || i_wready) begin
            state <= LINK_TX_DATA;
          end
        end
        LINK_TX_DATA: begin
          o_mem_addr <= '0;
          o_wdata    <= (tx_cnt < reply_len) ? i_mem_rdata : 8'h00;
          o_wvalid   <= 1'b1;
          tx_cnt     <= tx_cnt + 1'b1;
          state      <= (tx_cnt == TX_FRAME_BYTES - 1) ? LINK_IDLE : LINK_TX_ADDR;
        end
        default: state <= LINK_IDLE;
      endcase
    end
  end

  // no byte goes out while the processing side owns the buffer
  a_no_tx_during_proc: assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(o_wvalid) |-> !o_proc_start)
    else $error("transmit started during processing");

endmodule

`default_nettype wire

//--- hw/mhp_top.sv
`timescale 1ns/1ps
`default_nettype none

module mhp_top
  import mhp_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_rready,
  input  byte_t i_rdata,
  output logic  o_rreq,
  input  logic  i_wready,
  output byte_t o_wdata,
  output logic  o_wvalid,
  output logic  o_addr_granted
);

  logic      link_we;
  buf_addr_t link_addr;
  byte_t     link_wdata;
  logic      cp_we;
  buf_addr_t cp_addr;
  byte_t     cp_wdata;
  byte_t     mem_rdata;

  logic      proc_start;
  logic      proc_done;
  logic      reply_valid;
  buf_addr_t reply_len;
  logic      grant_seen;

  frame_buffer u_frame_buffer (
    .i_clk     (i_clk),
    .i_a_we    (link_we),
    .i_a_addr  (link_addr),
    .i_a_wdata (link_wdata),
    .i_b_we    (cp_we),
    .i_b_addr  (cp_addr),
    .i_b_wdata (cp_wdata),
    .o_rdata   (mem_rdata)
  );

  link_controller u_link_controller (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_rready       (i_rready),
    .i_rdata        (i_rdata),
    .o_rreq         (o_rreq),
    .i_wready       (i_wready),
    .o_wdata        (o_wdata),
    .o_wvalid       (o_wvalid),
    .o_addr_granted (o_addr_granted),
    .o_proc_start   (proc_start),
    .i_proc_done    (proc_done),
    .i_reply_valid  (reply_valid),
    .i_reply_len    (reply_len),
    .i_grant_seen   (grant_seen),
    .o_mem_we       (link_we),
    .o_mem_addr     (link_addr),
    .o_mem_wdata    (link_wdata),
    .i_mem_rdata    (mem_rdata)
  );

  command_processor u_command_processor (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_start       (proc_start),
    .o_done        (proc_done),
    .o_reply_valid (reply_valid),
    .o_reply_len   (reply_len),
    .o_grant_seen  (grant_seen),
    .i_granted     (o_addr_granted),
    .o_mem_we      (cp_we),
    .o_mem_addr    (cp_addr),
    .o_mem_wdata   (cp_wdata),
    .i_mem_rdata   (mem_rdata)
  );

endmodule

`default_nettype wire

//--- include/mhp_tb_ref.svh
`ifndef MHP_TB_REF_SVH
`define MHP_TB_REF_SVH

// template bytes as sent before patch and checksum
function automatic byte_t ref_tpl_byte(input cmd_t cmd, input int idx);
  byte_t ping [LEN_PING];
  byte_t req [LEN_ADDR_REQ];
  byte_t grant [LEN_ADDR_GRANT];
  ping  = '{8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h01, 8'h81, 8'h00, 8'h00, 8'h00};
  req   = '{8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h01, 8'h83, 8'h00, 8'h00, 8'h00,
            8'h00};
  grant = '{8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h02, 8'h92, 8'h01, 8'h20, 8'h00,
            8'h00};
  case (cmd)
    CMD_PING:     return ping[idx];
    CMD_ADDR_REQ: return req[idx];
    default:      return grant[idx];
  endcase
endfunction

// expected wire frame, returns 0 when the node stays silent
function automatic bit ref_reply(input byte_t hdr [HEADER_BYTES], input bit granted,
                                 output byte_t exp [TX_FRAME_BYTES], output bit grant_seen);
  cmd_t cmd;
  int   len;
  sum_t sum;
  foreach (exp[i]) exp[i] = 8'h00;
  grant_seen = 1'b0;
  if (hdr[HEADER_BYTES - 1][ACK_TYPE_BIT]) return 1'b0;
  cmd = granted ? hdr[HEADER_BYTES - 1][4:0] : CMD_ADDR_GRANT;
  case (cmd)
    CMD_PING:       len = LEN_PING;
    CMD_ADDR_REQ:   len = LEN_ADDR_REQ;
    CMD_ADDR_GRANT: len = LEN_ADDR_GRANT;
    default:        return 1'b0;
  endcase
  for (int i = 0; i < len; i++) exp[i] = ref_tpl_byte(cmd, i);
  // addresses swapped
  exp[0] = hdr[2];
  exp[1] = hdr[3];
  exp[2] = hdr[0];
  exp[3] = hdr[1];
  sum = '0;
  for (int i = 0; i < len - 2; i++) sum = sum + sum_t'(exp[i]);
  exp[len - 2] = sum[15:8];
  exp[len - 1] = sum[7:0];
  grant_seen = (cmd == CMD_ADDR_GRANT);
  return 1'b1;
endfunction

task automatic check_byte(input string name, input byte_t exp, input byte_t act);
  if (exp !== act) begin
    $display("MISMATCH %s expected %02h actual %02h", name, exp, act);
    $fatal(1, "%s failed", name);
  end
endtask

task automatic check_flag(input string name, input bit exp, input logic act);
  if (act !== exp) begin
    $display("MISMATCH %s expected %0b actual %0b", name, exp, act);
    $fatal(1, "%s failed", name);
  end
endtask

`endif

//--- verif/tb_mhp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mhp
  import mhp_pkg::*;
();

  localparam int NUM_FRAMES       = 7;
  localparam int CYCLES_PER_FRAME = 2000;

  logic  i_clk;
  logic  i_rst;
  logic  i_rready;
  byte_t i_rdata;
  logic  o_rreq;
  logic  i_wready;
  byte_t o_wdata;
  logic  o_wvalid;
  logic  o_addr_granted;

  int    seed;
  bit    granted_model;
  byte_t exp_q [$];
  string name_q [$];
  string cur_name;
  byte_t exp_byte;
  int    tx_idx;

  `include "mhp_tb_ref.svh"

  mhp_top dut (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_rready       (i_rready),
    .i_rdata        (i_rdata),
    .o_rreq         (o_rreq),
    .i_wready       (i_wready),
    .o_wdata        (o_wdata),
    .o_wvalid       (o_wvalid),
    .o_addr_granted (o_addr_granted)
  );

  always #4 i_clk = ~i_clk;

  task automatic announce_failure();
    $display("=== FAIL ===");
  endtask

  task automatic expect_byte(input string name, input byte_t exp, input byte_t act);
    if (exp !== act) begin
      announce_failure();
    end
    check_byte(name, exp, act);
  endtask

  task automatic expect_flag(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      announce_failure();
    end
    check_flag(name, exp, act);
  endtask

  //////////////////////////////
  // frame stimulus

  // one byte per o_rreq, then idle past the end-of-frame gap
  task automatic send_frame(input byte_t data [$]);
    foreach (data[i]) begin
      i_rdata  = data[i];
      i_rready = 1'b1;
      do begin
        @(negedge i_clk);
      end while (!o_rreq);
      @(posedge i_clk);
      #1;
    end
    i_rready = 1'b0;
    i_rdata  = '0;
    repeat (IDLE_GAP_CYCLES + 4) @(posedge i_clk);
    #1;
  endtask

  task automatic run_frame(input string name, input node_addr_t src, input node_addr_t dst,
                           input byte_t ftype, input int len);
    byte_t frame [$];
    byte_t hdr [HEADER_BYTES];
    byte_t exp [TX_FRAME_BYTES];
    bit    grant_seen;
    hdr[0] = src[15:8];
    hdr[1] = src[7:0];
    hdr[2] = dst[15:8];
    hdr[3] = dst[7:0];
    hdr[4] = 8'h00;
    hdr[5] = byte_t'(len);
    hdr[6] = ftype;
    for (int i = 0; i < len; i++) begin
      if (i < HEADER_BYTES) begin
        frame.push_back(hdr[i]);
      end else begin
        frame.push_back(byte_t'($random(seed)));
      end
    end
    // short frames never reach the parser
    if (len >= HEADER_BYTES && ref_reply(hdr, granted_model, exp, grant_seen)) begin
      foreach (exp[i]) begin
        exp_q.push_back(exp[i]);
      end
      name_q.push_back(name);
      granted_model = granted_model | grant_seen;
    end
    send_frame(frame);
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
    end
    @(posedge i_clk);
    #1;
  endtask

  //////////////////////////////
  // reply collector and compare
  always @(negedge i_clk) begin
    if (!i_rst) begin
      if (o_rreq) begin
        expect_flag("rreq only with rready", 1'b1, i_rready);
      end
      if (o_wvalid) begin
        if (exp_q.size() == 0) begin
          announce_failure();
          $fatal(1, "a byte was transmitted while no reply was expected");
        end else begin
          if (tx_idx == 0) begin
            cur_name = name_q.pop_front();
          end
          exp_byte = exp_q.pop_front();
          expect_byte($sformatf("%s byte %0d", cur_name, tx_idx), exp_byte, o_wdata);
          tx_idx = (tx_idx + 1) % TX_FRAME_BYTES;
        end
      end
    end
  end

  initial begin
    seed          = 17;
    granted_model = 1'b0;
    tx_idx        = 0;
    cur_name      = "";
    i_clk         = 1'b0;
    i_rst         = 1'b1;
    i_rready      = 1'b0;
    i_rdata       = '0;
    i_wready      = 1'b1;
    repeat (8) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    @(negedge i_clk);
    expect_flag("reset rreq", 1'b0, o_rreq);
    expect_flag("reset wvalid", 1'b0, o_wvalid);
    expect_flag("reset granted", 1'b0, o_addr_granted);
    @(posedge i_clk);
    #1;

    // an ack gets no reply, not even a grant
    run_frame("ack frame", 16'h1111, 16'h2222, 8'h11, 8);

    // unaddressed node answers with a grant
    run_frame("grant", 16'h0a31, 16'h0001, 8'h03, 7);
    wait_drained();
    expect_flag("granted after grant", 1'b1, o_addr_granted);

    // sink not ready holds the reply back
    i_wready = 1'b0;
    run_frame("ping", 16'h4c02, 16'h0a31, 8'h01, 9);
    repeat (150) @(posedge i_clk);
    #1;
    expect_flag("ping waits for wready", 1'b1, exp_q.size() == TX_FRAME_BYTES);
    i_wready = 1'b1;
    wait_drained();

    run_frame("addr req", 16'h7e19, 16'hb004, 8'h03, 7 + ($unsigned($random(seed)) % 14));
    wait_drained();

    // buffer still holds the request type behind the short frame
    run_frame("short frame", 16'h5555, 16'h6666, 8'h01, 5);
    run_frame("unknown type", 16'h3333, 16'h4444, 8'h09, 7);
    run_frame("ping after drops", 16'h9a0b, 16'hc1d2, 8'h01, 7);
    wait_drained();

    $display("=== PASS ===");
    $finish;
  end

  initial begin
    repeat (NUM_FRAMES * CYCLES_PER_FRAME) @(posedge i_clk);
    announce_failure();
    $fatal(1, "watchdog expired before all frames were answered");
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
hw/mhp_pkg.sv
hw/frame_buffer.sv
hw/reply_template.sv
hw/checksum_unit.sv
hw/command_processor.sv
hw/link_controller.sv
hw/mhp_top.sv
verif/tb_mhp.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --top-module tb_mhp -f src.f -o tb_mhp_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mhp_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "=== FAIL ===" "$SIM_LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0
